// File: dv/lc3b_assert.sv
module lc3b_assert (
    input logic                    clk,
    input logic                    rst_n,
    input lc3b_ctrl_pkg::mem_req_t mem_req,
    input logic                    mem_resp
);

    int fail_count = 0;

    // One strobe at a time
    read_write_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_req.read && mem_req.write))
        else begin
            fail_count++;
            $error("read and write high together");
        end

    // Strobe, address and data held until the response
    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req.read || mem_req.write) && !mem_resp |=> $stable(mem_req))
        else begin
            fail_count++;
            $error("memory request changed before mem_resp");
        end

    idle_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !mem_req.read && !mem_req.write)
        else begin
            fail_count++;
            $error("memory strobe high in the cycle of reset release");
        end

endmodule : lc3b_assert

bind lc3b_cpu lc3b_assert u_assert (
    .clk      (clk),
    .rst_n    (rst_n),
    .mem_req  (mem_req),
    .mem_resp (mem_resp)
);

// File: dv/lc3b_stim.txt
# P <byte address> <word>  program and data image, hex
# S <byte address> <data>  expected stores in order, hex
P 0000 EC3F  # LEA R6, 63 -> R6 = 0080
P 0002 6380  # LDR R1, R6, 0 -> 1234
P 0004 6581  # LDR R2, R6, 1 -> 0F0F
P 0006 1642  # ADD R3, R1, R2 -> 2143
P 0008 7788  # STR R3, R6, 8
P 000A 187D  # ADD R4, R1, #-3 -> 1231
P 000C 7989  # STR R4, R6, 9
P 000E 5A42  # AND R5, R1, R2 -> 0204
P 0010 7B8A  # STR R5, R6, 10
P 0012 5AA7  # AND R5, R2, #7 -> 0007
P 0014 7B8B  # STR R5, R6, 11
P 0016 967F  # NOT R3, R1 -> EDCB, CC = N
P 0018 778C  # STR R3, R6, 12
P 001A 0601  # BRzp +1, not taken
P 001C 798D  # STR R4, R6, 13
P 001E 0801  # BRn +1, taken
P 0020 778E  # STR R3, R6, 14, skipped
P 0022 6382  # LDR R1, R6, 2 -> 0000, CC = Z
P 0024 0401  # BRz +1, taken
P 0026 758F  # STR R2, R6, 15, skipped
P 0028 0A01  # BRnp +1, not taken
P 002A 7590  # STR R2, R6, 16
P 002C 6583  # LDR R2, R6, 3 -> BEEF
P 002E 7591  # STR R2, R6, 17
P 0030 75BF  # STR R2, R6, -1
P 0032 E003  # LEA R0, 3 -> 003A
P 0034 7192  # STR R0, R6, 18
P 0036 C000  # JMP R0, R7 = 0038
P 0038 7193  # STR R0, R6, 19, skipped
P 003A 7F94  # STR R7, R6, 20
P 003C 0FFF  # BRnzp to itself
P 0080 1234
P 0082 0F0F
P 0084 0000
P 0086 BEEF
S 0090 2143
S 0092 1231
S 0094 0204
S 0096 0007
S 0098 EDCB
S 009A 1231
S 00A0 0F0F
S 00A2 BEEF
S 007E BEEF
S 00A4 003A
S 00A8 0038

// File: dv/lc3b_tb.sv
module lc3b_tb;

    logic                    clk       = 1'b0;
    logic                    rst_n     = 1'b0;
    lc3b_isa_pkg::lc3b_word  mem_rdata = '0;
    logic                    mem_resp  = 1'b0;
    lc3b_ctrl_pkg::mem_req_t mem_req;

    // Word-addressed backing store indexed by address[15:1]
    lc3b_isa_pkg::lc3b_word mem [0:32767];
    lc3b_isa_pkg::lc3b_word exp_addr [$];
    lc3b_isa_pkg::lc3b_word exp_data [$];

    int          mismatches      = 0;
    int          other_errors    = 0;
    int          assert_fails    = 0;
    int          prog_words      = 0;
    int          watchdog_cycles = 0;
    int unsigned delay_left      = 0;
    logic        busy            = 1'b0;
    logic        first_seen      = 1'b0;

    lc3b_cpu u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_rdata (mem_rdata),
        .mem_resp  (mem_resp),
        .mem_req   (mem_req)
    );

    always #50 clk = ~clk;

    task automatic check_value(input string name, input lc3b_isa_pkg::lc3b_word got,
                               input lc3b_isa_pkg::lc3b_word expected);
        if (got !== expected) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, expected);
            mismatches++;
        end
    endtask

    task automatic load_stim();
        int                     fd;
        int                     n;
        logic [7:0]             tag;
        lc3b_isa_pkg::lc3b_word addr;
        lc3b_isa_pkg::lc3b_word data;
        logic [8*128-1:0]       rest;
        logic                   done;
        fd = $fopen("dv/lc3b_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file dv/lc3b_stim.txt");
            other_errors++;
            return;
        end
        done = 1'b0;
        while (!done) begin
            n = $fscanf(fd, " %c", tag);
            if (n != 1) begin
                done = 1'b1;
            end else if (tag == "#") begin
                // Comment runs to the end of the line
                n = $fgets(rest, fd);
            end else begin
                n = $fscanf(fd, " %h %h", addr, data);
                if (n != 2) begin
                    $display("malformed record in the stimulus file");
                    other_errors++;
                    done = 1'b1;
                end else if (tag == "P") begin
                    mem[addr[15:1]] = data;
                    prog_words++;
                end else if (tag == "S") begin
                    exp_addr.push_back(addr);
                    exp_data.push_back(data);
                end else begin
                    $display("unknown record tag in the stimulus file");
                    other_errors++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic record_store(input lc3b_isa_pkg::lc3b_word addr,
                                input lc3b_isa_pkg::lc3b_word data);
        if (exp_addr.size() == 0) begin
            $display("store of 0x%h to address 0x%h came after the last expected store",
                     data, addr);
            other_errors++;
        end else begin
            check_value("mem_req.address", addr, exp_addr.pop_front());
            check_value("mem_req.wdata", data, exp_data.pop_front());
        end
    endtask

    // Memory model that answers each request after 1 to 4 cycles
    always @(posedge clk) begin
        if (!rst_n) begin
            mem_resp <= 1'b0;
            busy = 1'b0;
        end else if (mem_resp) begin
            // Request drops on this edge
            mem_resp <= 1'b0;
            busy = 1'b0;
        end else if (mem_req.read || mem_req.write) begin
            if (!first_seen) begin
                first_seen = 1'b1;
                check_value("mem_req.read", {15'b0, mem_req.read}, 16'h0001);
                check_value("mem_req.address", mem_req.address, 16'h0000);
            end
            if (!busy) begin
                busy = 1'b1;
                delay_left = $urandom % 4;
            end
            if (delay_left != 0) begin
                delay_left--;
            end else begin
                mem_resp <= 1'b1;
                if (mem_req.read) begin
                    mem_rdata <= mem[mem_req.address[15:1]];
                end else begin
                    record_store(mem_req.address, mem_req.wdata);
                    mem[mem_req.address[15:1]] = mem_req.wdata;
                end
            end
        end
    end

    initial begin
        void'($urandom(88934));
        // Unprogrammed words hold the inverted byte address
        for (int i = 0; i < 32768; i++) begin
            mem[i] = ~lc3b_isa_pkg::lc3b_word'(2 * i);
        end
        load_stim();
        watchdog_cycles = prog_words * 40 + 2000;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        while (exp_addr.size() != 0) begin
            @(posedge clk);
        end
        // Program now spins on its final BR so any stray store still shows up
        repeat (200) @(posedge clk);
        assert_fails = u_dut.u_assert.fail_count;
        $display("mismatches: %0d, other errors: %0d, assertion failures: %0d",
                 mismatches, other_errors, assert_fails);
        if (mismatches + other_errors + assert_fails == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout after %0d cycles, %0d store records never seen",
                 watchdog_cycles, exp_addr.size());
        $display("tests failed");
        $finish;
    end

endmodule : lc3b_tb

// File: hw/lc3b_control.sv
module lc3b_control (
    input  logic                     clk,
    input  logic                     rst_n,
    input  lc3b_isa_pkg::lc3b_opcode opcode,
    input  logic                     inst5,
    input  logic                     branch_enable,
    input  logic                     mem_resp,
    output lc3b_ctrl_pkg::ctrl_word_t ctrl,
    output logic                     mem_read,
    output logic                     mem_write
);

    typedef enum logic [3:0] {
        s_fetch1,
        s_fetch2,
        s_fetch3,
        s_decode,
        s_add,
        s_and,
        s_not,
        s_br,
        s_br_taken,
        s_calc_addr,
        s_ldr1,
        s_ldr2,
        s_str1,
        s_str2,
        s_lea,
        s_jmp
    } state_t;

    state_t state;
    state_t next_state;

    always_comb begin
        ctrl       = '0;
        ctrl.aluop = lc3b_isa_pkg::alu_add;
        mem_read   = 1'b0;
        mem_write  = 1'b0;

        case (state)
            s_fetch1: begin
                // MAR <- PC, PC <- PC + 2
                ctrl.marmux_sel = lc3b_ctrl_pkg::marmux_pc;
                ctrl.load_mar   = 1'b1;
                ctrl.pcmux_sel  = lc3b_ctrl_pkg::pcmux_plus2;
                ctrl.load_pc    = 1'b1;
            end
            s_fetch2, s_ldr1: begin
                // Wait here for the read data
                mem_read        = 1'b1;
                ctrl.mdrmux_sel = lc3b_ctrl_pkg::mdrmux_mem;
                ctrl.load_mdr   = 1'b1;
            end
            s_fetch3: begin
                ctrl.load_ir = 1'b1;
            end
            s_add, s_and: begin
                ctrl.alumux_sel     = inst5 ? lc3b_ctrl_pkg::alumux_imm5
                                            : lc3b_ctrl_pkg::alumux_sr2;
                ctrl.aluop          = (state == s_and) ? lc3b_isa_pkg::alu_and
                                                       : lc3b_isa_pkg::alu_add;
                ctrl.regfilemux_sel = lc3b_ctrl_pkg::regfilemux_alu;
                ctrl.load_cc        = 1'b1;
                ctrl.load_regfile   = 1'b1;
            end
            s_not: begin
                ctrl.aluop          = lc3b_isa_pkg::alu_not;
                ctrl.regfilemux_sel = lc3b_ctrl_pkg::regfilemux_alu;
                ctrl.load_cc        = 1'b1;
                ctrl.load_regfile   = 1'b1;
            end
            s_br_taken: begin
                ctrl.pcmux_sel = lc3b_ctrl_pkg::pcmux_br;
                ctrl.load_pc   = 1'b1;
            end
            s_calc_addr: begin
                // MAR <- BaseR + (sext offset6 << 1)
                ctrl.alumux_sel = lc3b_ctrl_pkg::alumux_off6;
                ctrl.marmux_sel = lc3b_ctrl_pkg::marmux_alu;
                ctrl.load_mar   = 1'b1;
            end
            s_ldr2: begin
                ctrl.regfilemux_sel = lc3b_ctrl_pkg::regfilemux_mdr;
                ctrl.load_cc        = 1'b1;
                ctrl.load_regfile   = 1'b1;
            end
            s_str1: begin
                // Source register through the ALU into MDR
                ctrl.storemux_sel = lc3b_ctrl_pkg::storemux_dr;
                ctrl.aluop        = lc3b_isa_pkg::alu_pass;
                ctrl.mdrmux_sel   = lc3b_ctrl_pkg::mdrmux_alu;
                ctrl.load_mdr     = 1'b1;
            end
            s_str2: begin
                mem_write = 1'b1;
            end
            s_lea: begin
                ctrl.regfilemux_sel = lc3b_ctrl_pkg::regfilemux_lea;
                ctrl.load_cc        = 1'b1;
                ctrl.load_regfile   = 1'b1;
            end
            s_jmp: begin
                // PC <- BaseR and R7 <- PC in the same cycle
                ctrl.pcmux_sel      = lc3b_ctrl_pkg::pcmux_sr1;
                ctrl.load_pc        = 1'b1;
                ctrl.regfilemux_sel = lc3b_ctrl_pkg::regfilemux_pc;
                ctrl.destmux_sel    = lc3b_ctrl_pkg::destmux_r7;
                ctrl.load_regfile   = 1'b1;
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        next_state = s_fetch1;

        case (state)
            s_fetch1:    next_state = s_fetch2;
            s_fetch2:    next_state = mem_resp ? s_fetch3 : s_fetch2;
            s_fetch3:    next_state = s_decode;
            s_decode: begin
                case (opcode)
                    lc3b_isa_pkg::op_add: next_state = s_add;
                    lc3b_isa_pkg::op_and: next_state = s_and;
                    lc3b_isa_pkg::op_not: next_state = s_not;
                    lc3b_isa_pkg::op_br:  next_state = s_br;
                    lc3b_isa_pkg::op_ldr: next_state = s_calc_addr;
                    lc3b_isa_pkg::op_str: next_state = s_calc_addr;
                    lc3b_isa_pkg::op_lea: next_state = s_lea;
                    lc3b_isa_pkg::op_jmp: next_state = s_jmp;
                    default:              next_state = s_fetch1;
                endcase
            end
            s_br:        next_state = branch_enable ? s_br_taken : s_fetch1;
            s_calc_addr: begin
                // IR still holds the opcode that led here
                next_state = (opcode == lc3b_isa_pkg::op_ldr) ? s_ldr1 : s_str1;
            end
            s_ldr1:      next_state = mem_resp ? s_ldr2 : s_ldr1;
            s_str1:      next_state = s_str2;
            s_str2:      next_state = mem_resp ? s_fetch1 : s_str2;
            default:     next_state = s_fetch1;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= s_fetch1;
        end else begin
            state <= next_state;
        end
    end

endmodule : lc3b_control

// File: hw/lc3b_cpu.sv
module lc3b_cpu (
    input  logic                    clk,
    input  logic                    rst_n,
    input  lc3b_isa_pkg::lc3b_word  mem_rdata,
    input  logic                    mem_resp,
    output lc3b_ctrl_pkg::mem_req_t mem_req
);

    lc3b_ctrl_pkg::ctrl_word_t ctrl;
    lc3b_isa_pkg::lc3b_opcode  opcode;
    logic                      inst5;
    logic                      branch_enable;
    logic                      mem_read;
    logic                      mem_write;
    lc3b_isa_pkg::lc3b_word    mem_address;
    lc3b_isa_pkg::lc3b_word    mem_wdata;

    lc3b_control u_control (
        .clk           (clk),
        .rst_n         (rst_n),
        .opcode        (opcode),
        .inst5         (inst5),
        .branch_enable (branch_enable),
        .mem_resp      (mem_resp),
        .ctrl          (ctrl),
        .mem_read      (mem_read),
        .mem_write     (mem_write)
    );

    lc3b_datapath u_datapath (
        .clk           (clk),
        .rst_n         (rst_n),
        .ctrl          (ctrl),
        .mem_rdata     (mem_rdata),
        .mem_resp      (mem_resp),
        .opcode        (opcode),
        .inst5         (inst5),
        .branch_enable (branch_enable),
        .mem_address   (mem_address),
        .mem_wdata     (mem_wdata)
    );

    // Strobes from control, address and data from MAR and MDR
    assign mem_req.read    = mem_read;
    assign mem_req.write   = mem_write;
    assign mem_req.address = mem_address;
    assign mem_req.wdata   = mem_wdata;

endmodule : lc3b_cpu

// File: hw/lc3b_ctrl_pkg.sv
package lc3b_ctrl_pkg;

    typedef logic [1:0] pcmux_sel_t;
    typedef logic [1:0] alumux_sel_t;
    typedef logic [1:0] regfilemux_sel_t;
    typedef logic       marmux_sel_t;
    typedef logic       storemux_sel_t;
    typedef logic       destmux_sel_t;
    typedef logic       mdrmux_sel_t;

    // PC source
    localparam pcmux_sel_t pcmux_plus2 = 2'b00;
    localparam pcmux_sel_t pcmux_br    = 2'b01;
    localparam pcmux_sel_t pcmux_sr1   = 2'b10;

    // ALU operand B
    localparam alumux_sel_t alumux_sr2  = 2'b00;
    localparam alumux_sel_t alumux_imm5 = 2'b01;
    localparam alumux_sel_t alumux_off6 = 2'b10;

    // Register write data
    localparam regfilemux_sel_t regfilemux_alu = 2'b00;
    localparam regfilemux_sel_t regfilemux_mdr = 2'b01;
    localparam regfilemux_sel_t regfilemux_lea = 2'b10;
    localparam regfilemux_sel_t regfilemux_pc  = 2'b11;

    localparam marmux_sel_t   marmux_alu   = 1'b0;
    localparam marmux_sel_t   marmux_pc    = 1'b1;
    // SR1 comes from IR[8:6] or, for STR data, IR[11:9]
    localparam storemux_sel_t storemux_sr1 = 1'b0;
    localparam storemux_sel_t storemux_dr  = 1'b1;
    localparam destmux_sel_t  destmux_ir   = 1'b0;
    localparam destmux_sel_t  destmux_r7   = 1'b1;
    localparam mdrmux_sel_t   mdrmux_alu   = 1'b0;
    localparam mdrmux_sel_t   mdrmux_mem   = 1'b1;

    typedef struct packed {
        logic                    load_pc;
        logic                    load_ir;
        logic                    load_regfile;
        logic                    load_mar;
        logic                    load_mdr;
        logic                    load_cc;
        pcmux_sel_t              pcmux_sel;
        alumux_sel_t             alumux_sel;
        regfilemux_sel_t         regfilemux_sel;
        marmux_sel_t             marmux_sel;
        storemux_sel_t           storemux_sel;
        destmux_sel_t            destmux_sel;
        mdrmux_sel_t             mdrmux_sel;
        lc3b_isa_pkg::lc3b_aluop aluop;
    } ctrl_word_t;

    // One word-wide memory request, held until the response
    typedef struct packed {
        logic                   read;
        logic                   write;
        lc3b_isa_pkg::lc3b_word address;
        lc3b_isa_pkg::lc3b_word wdata;
    } mem_req_t;

endpackage : lc3b_ctrl_pkg

// File: hw/lc3b_datapath.sv
module lc3b_datapath (
    input  logic                      clk,
    input  logic                      rst_n,
    input  lc3b_ctrl_pkg::ctrl_word_t ctrl,
    input  lc3b_isa_pkg::lc3b_word    mem_rdata,
    input  logic                      mem_resp,
    output lc3b_isa_pkg::lc3b_opcode  opcode,
    output logic                      inst5,
    output logic                      branch_enable,
    output lc3b_isa_pkg::lc3b_word    mem_address,
    output lc3b_isa_pkg::lc3b_word    mem_wdata
);

    localparam int msb = lc3b_isa_pkg::word_w - 1;

    lc3b_isa_pkg::lc3b_word pc;
    lc3b_isa_pkg::lc3b_word ir;
    lc3b_isa_pkg::lc3b_word mar;
    lc3b_isa_pkg::lc3b_word mdr;
    logic [2:0]             nzp;
    logic [2:0]             nzp_next;

    lc3b_isa_pkg::lc3b_reg  sr1;
    lc3b_isa_pkg::lc3b_reg  dest;
    lc3b_isa_pkg::lc3b_word reg_a;
    lc3b_isa_pkg::lc3b_word reg_b;

    lc3b_isa_pkg::lc3b_word sext_imm5;
    lc3b_isa_pkg::lc3b_word sext_off6;
    lc3b_isa_pkg::lc3b_word sext_off9;
    lc3b_isa_pkg::lc3b_word alu_b;
    lc3b_isa_pkg::lc3b_word alu_out;
    lc3b_isa_pkg::lc3b_word pc_plus2;
    lc3b_isa_pkg::lc3b_word br_target;
    lc3b_isa_pkg::lc3b_word regfile_in;

    // Offsets are word counts, so shift left by one for a byte address
    assign sext_imm5 = {{11{ir[4]}}, ir[4:0]};
    assign sext_off6 = {{9{ir[5]}}, ir[5:0], 1'b0};
    assign sext_off9 = {{6{ir[8]}}, ir[8:0], 1'b0};
    assign pc_plus2  = pc + 16'd2;
    // Shared by BR and LEA
    assign br_target = pc + sext_off9;

    assign sr1  = (ctrl.storemux_sel == lc3b_ctrl_pkg::storemux_dr) ? ir[11:9] : ir[8:6];
    assign dest = (ctrl.destmux_sel == lc3b_ctrl_pkg::destmux_r7) ? lc3b_isa_pkg::link_reg
                                                                  : ir[11:9];

    lc3b_regfile u_regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (ctrl.load_regfile),
        .sr1   (sr1),
        .sr2   (ir[2:0]),
        .dest  (dest),
        .in    (regfile_in),
        .reg_a (reg_a),
        .reg_b (reg_b)
    );

    always_comb begin
        case (ctrl.alumux_sel)
            lc3b_ctrl_pkg::alumux_imm5: alu_b = sext_imm5;
            lc3b_ctrl_pkg::alumux_off6: alu_b = sext_off6;
            default:                    alu_b = reg_b;
        endcase

        case (ctrl.aluop)
            lc3b_isa_pkg::alu_add: alu_out = reg_a + alu_b;
            lc3b_isa_pkg::alu_and: alu_out = reg_a & alu_b;
            lc3b_isa_pkg::alu_not: alu_out = ~reg_a;
            default:               alu_out = reg_a;
        endcase

        case (ctrl.regfilemux_sel)
            lc3b_ctrl_pkg::regfilemux_mdr: regfile_in = mdr;
            lc3b_ctrl_pkg::regfilemux_lea: regfile_in = br_target;
            lc3b_ctrl_pkg::regfilemux_pc:  regfile_in = pc;
            default:                       regfile_in = alu_out;
        endcase
    end

    // N, Z, P from the value being written back
    assign nzp_next = {regfile_in[msb], regfile_in == '0,
                       !regfile_in[msb] && (regfile_in != '0)};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc  <= '0;
            nzp <= 3'b010;
        end else begin
            if (ctrl.load_pc) begin
                case (ctrl.pcmux_sel)
                    lc3b_ctrl_pkg::pcmux_br:  pc <= br_target;
                    lc3b_ctrl_pkg::pcmux_sr1: pc <= reg_a;
                    default:                  pc <= pc_plus2;
                endcase
            end
            if (ctrl.load_cc) begin
                nzp <= nzp_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.load_ir) begin
            ir <= mdr;
        end
        if (ctrl.load_mar) begin
            mar <= (ctrl.marmux_sel == lc3b_ctrl_pkg::marmux_pc) ? pc : alu_out;
        end
        // A read still waiting leaves MDR as it was
        if (ctrl.load_mdr) begin
            if (ctrl.mdrmux_sel == lc3b_ctrl_pkg::mdrmux_mem) begin
                if (mem_resp) begin
                    mdr <= mem_rdata;
                end
            end else begin
                mdr <= alu_out;
            end
        end
    end

    assign opcode        = lc3b_isa_pkg::lc3b_opcode'(ir[15:12]);
    assign inst5         = ir[5];
    assign branch_enable = |(nzp & ir[11:9]);
    assign mem_address   = mar;
    assign mem_wdata     = mdr;

endmodule : lc3b_datapath

// File: hw/lc3b_isa_pkg.sv
package lc3b_isa_pkg;

    // Datapath and register file geometry
    localparam int word_w   = 16;
    localparam int reg_w    = 3;
    localparam int opcode_w = 4;
    localparam int num_regs = 1 << reg_w;

    // Data word and address word share one width
    typedef logic [word_w-1:0] lc3b_word;

    // Register index into R0..R7
    typedef logic [reg_w-1:0] lc3b_reg;

    // JMP writes the return address here
    localparam lc3b_reg link_reg = 3'd7;

    // IR[15:12], only the supported subset is named
    typedef enum logic [opcode_w-1:0] {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_and = 4'b0101,
        op_not = 4'b1001,
        op_jmp = 4'b1100,
        op_lea = 4'b1110
    } lc3b_opcode;

    // ALU function select
    // alu_pass forwards operand A unchanged, used for STR data
    typedef enum logic [1:0] {
        alu_add  = 2'b00,
        alu_and  = 2'b01,
        alu_not  = 2'b10,
        alu_pass = 2'b11
    } lc3b_aluop;

endpackage : lc3b_isa_pkg

// File: hw/lc3b_regfile.sv
module lc3b_regfile (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   load,
    input  lc3b_isa_pkg::lc3b_reg  sr1,
    input  lc3b_isa_pkg::lc3b_reg  sr2,
    input  lc3b_isa_pkg::lc3b_reg  dest,
    input  lc3b_isa_pkg::lc3b_word in,
    output lc3b_isa_pkg::lc3b_word reg_a,
    output lc3b_isa_pkg::lc3b_word reg_b
);

    lc3b_isa_pkg::lc3b_word regs [lc3b_isa_pkg::num_regs];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < lc3b_isa_pkg::num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (load) begin
            regs[dest] <= in;
        end
    end

    // Reads see the old value during a write cycle
    assign reg_a = regs[sr1];
    assign reg_b = regs[sr2];

endmodule : lc3b_regfile

// File: run.sh
#!/bin/sh
# Build the LC-3b testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f tb.f --top-module lc3b_tb -o lc3b_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/lc3b_sim +verilator+error+limit+100)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "all tests passed"; then
    exit 0
fi
exit 1

// File: tb.f
hw/lc3b_isa_pkg.sv
hw/lc3b_ctrl_pkg.sv
hw/lc3b_regfile.sv
hw/lc3b_control.sv
hw/lc3b_datapath.sv
hw/lc3b_cpu.sv
dv/lc3b_assert.sv
dv/lc3b_tb.sv
